//--- hdl/standby_pkg.sv
// Bus widths are fixed; lane 0 carries I2C and lane 1 carries I3C
package standby_pkg;

  // Physical bus lanes, indexed like the controller SCL/SDA arrays
  localparam int unsigned NumLanes = 2;
  localparam int unsigned LaneI2c = 0;
  localparam int unsigned LaneI3c = 1;

  // Flops in each SCL/SDA synchronizer
  localparam int unsigned SyncStages = 2;

  // Address with RnW in bit 0, or a data byte
  typedef logic [7:0] byte_t;

  // Static or dynamic target address
  typedef logic [6:0] addr7_t;

  typedef enum logic [2:0] {
    Idle,
    AddrShift,
    AddrAck,
    DataShift,
    DataAck,
    Ignore
  } rx_state_e;

endpackage

//--- hdl/bus_input_sync.sv
// Both lanes idle high while deselected; lane 0 needs an I2C enable, lane 1 wins over lane 0
module bus_input_sync (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                ctrl_scl_i [standby_pkg::NumLanes],
  input  logic                ctrl_sda_i [standby_pkg::NumLanes],
  input  logic                phy_en_i,
  input  logic                i2c_active_en_i,
  input  logic                i2c_standby_en_i,
  input  logic                i3c_active_en_i,
  input  logic                i3c_standby_en_i,
  input  standby_pkg::addr7_t target_sta_addr_i,
  input  logic                target_sta_addr_valid_i,
  input  standby_pkg::addr7_t target_dyn_addr_i,
  input  logic                target_dyn_addr_valid_i,
  output logic                lane_scl_o [standby_pkg::NumLanes],
  output logic                lane_sda_o [standby_pkg::NumLanes],
  output standby_pkg::addr7_t lane_addr_o [standby_pkg::NumLanes],
  output logic                lane_addr_valid_o [standby_pkg::NumLanes],
  output logic                lane_sel_o
);

  logic [standby_pkg::SyncStages-1:0] scl_sync_q [standby_pkg::NumLanes];
  logic [standby_pkg::SyncStages-1:0] sda_sync_q [standby_pkg::NumLanes];
  logic                               lane_en [standby_pkg::NumLanes];

  // I3C takes the bus when either I3C mode is on
  assign lane_sel_o = i3c_active_en_i | i3c_standby_en_i;
  assign lane_en[standby_pkg::LaneI2c] = phy_en_i & ~lane_sel_o &
                                         (i2c_active_en_i | i2c_standby_en_i);
  assign lane_en[standby_pkg::LaneI3c] = phy_en_i & lane_sel_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < standby_pkg::NumLanes; i++) begin
        scl_sync_q[i] <= '1;
        sda_sync_q[i] <= '1;
      end
    end else begin
      for (int i = 0; i < standby_pkg::NumLanes; i++) begin
        scl_sync_q[i] <= {scl_sync_q[i][standby_pkg::SyncStages-2:0], ctrl_scl_i[i]};
        sda_sync_q[i] <= {sda_sync_q[i][standby_pkg::SyncStages-2:0], ctrl_sda_i[i]};
      end
    end
  end

  // Deselected lane looks like a released bus
  always_comb begin
    for (int i = 0; i < standby_pkg::NumLanes; i++) begin
      lane_scl_o[i] = scl_sync_q[i][standby_pkg::SyncStages-1] | ~lane_en[i];
      lane_sda_o[i] = sda_sync_q[i][standby_pkg::SyncStages-1] | ~lane_en[i];
    end
  end

  assign lane_addr_o[standby_pkg::LaneI2c] = target_sta_addr_i;
  assign lane_addr_valid_o[standby_pkg::LaneI2c] = target_sta_addr_valid_i;

  // Dynamic address replaces the static one once assigned
  assign lane_addr_o[standby_pkg::LaneI3c] = target_dyn_addr_valid_i ? target_dyn_addr_i
                                                                      : target_sta_addr_i;
  assign lane_addr_valid_o[standby_pkg::LaneI3c] = target_dyn_addr_valid_i |
                                                   target_sta_addr_valid_i;

endmodule

//--- hdl/bus_frame_receiver.sv
// Write transfers only; each SCL phase must span several clk_i cycles, no clock stretching
module bus_frame_receiver (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                scl_i,
  input  logic                sda_i,
  input  standby_pkg::addr7_t own_addr_i,
  input  logic                own_addr_valid_i,
  output logic                sda_o,
  output logic                start_o,
  output logic                rstart_o,
  output logic                stop_o,
  output standby_pkg::byte_t  addr_o,
  output logic                addr_valid_o,
  output standby_pkg::byte_t  data_o,
  output logic                data_valid_o
);

  standby_pkg::rx_state_e state_q;
  standby_pkg::byte_t     shift_q;
  standby_pkg::byte_t     shift_next;
  logic [2:0]             bit_cnt_q;
  logic                   scl_q;
  logic                   sda_q;
  logic                   ack_drive_q;
  logic                   scl_rise;
  logic                   scl_fall;
  logic                   start_cond;
  logic                   stop_cond;
  logic                   byte_done;
  logic                   addr_match;
  logic                   in_frame;

  assign scl_rise = scl_i & ~scl_q;
  assign scl_fall = ~scl_i & scl_q;

  // SDA may only move while SCL is high for a bus condition
  assign start_cond = scl_i & scl_q & sda_q & ~sda_i;
  assign stop_cond = scl_i & scl_q & ~sda_q & sda_i;

  // MSB first
  assign shift_next = {shift_q[6:0], sda_i};
  assign byte_done = scl_rise & (bit_cnt_q == 3'd7);

  // Write to our own address only
  assign addr_match = own_addr_valid_i & (shift_next[7:1] == own_addr_i) & ~shift_next[0];

  assign in_frame = (state_q != standby_pkg::Idle);

  // Open-drain ACK, released otherwise
  assign sda_o = ~ack_drive_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scl_q <= 1'b1;
      sda_q <= 1'b1;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      start_o  <= 1'b0;
      rstart_o <= 1'b0;
      stop_o   <= 1'b0;
    end else begin
      start_o  <= start_cond & ~in_frame;
      rstart_o <= start_cond & in_frame;
      stop_o   <= stop_cond;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= standby_pkg::Idle;
      bit_cnt_q    <= '0;
      ack_drive_q  <= 1'b0;
      addr_valid_o <= 1'b0;
      data_valid_o <= 1'b0;
    end else begin
      addr_valid_o <= 1'b0;
      data_valid_o <= 1'b0;
      if (start_cond) begin
        state_q     <= standby_pkg::AddrShift;
        bit_cnt_q   <= '0;
        ack_drive_q <= 1'b0;
      end else if (stop_cond) begin
        state_q     <= standby_pkg::Idle;
        ack_drive_q <= 1'b0;
      end else begin
        case (state_q)
          standby_pkg::AddrShift: begin
            if (scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
            end
            if (byte_done) begin
              addr_valid_o <= 1'b1;
              state_q      <= addr_match ? standby_pkg::AddrAck : standby_pkg::Ignore;
            end
          end
          standby_pkg::DataShift: begin
            if (scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
            end
            if (byte_done) begin
              data_valid_o <= 1'b1;
              state_q      <= standby_pkg::DataAck;
            end
          end
          // Pull low after the 8th falling SCL, let go after the 9th
          standby_pkg::AddrAck, standby_pkg::DataAck: begin
            if (scl_fall) begin
              if (!ack_drive_q) begin
                ack_drive_q <= 1'b1;
              end else begin
                ack_drive_q <= 1'b0;
                state_q     <= standby_pkg::DataShift;
              end
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (scl_rise) begin
      shift_q <= shift_next;
    end
    if (byte_done && state_q == standby_pkg::AddrShift) begin
      addr_o <= shift_next;
    end
    if (byte_done && state_q == standby_pkg::DataShift) begin
      data_o <= shift_next;
    end
  end

endmodule

//--- hdl/tti_rx_mux.sv
// One-byte buffer toward the RX data queue; a byte arriving while it is full is lost
module tti_rx_mux (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               lane_sel_i,
  input  logic               start_i [standby_pkg::NumLanes],
  input  logic               rstart_i [standby_pkg::NumLanes],
  input  logic               stop_i [standby_pkg::NumLanes],
  input  standby_pkg::byte_t addr_i [standby_pkg::NumLanes],
  input  logic               addr_valid_i [standby_pkg::NumLanes],
  input  standby_pkg::byte_t data_i [standby_pkg::NumLanes],
  input  logic               data_valid_i [standby_pkg::NumLanes],
  input  logic               rx_queue_wready_i,
  output logic               rx_queue_wvalid_o,
  output standby_pkg::byte_t rx_queue_wdata_o,
  output logic               bus_start_o,
  output logic               bus_rstart_o,
  output logic               bus_stop_o,
  output standby_pkg::byte_t bus_addr_o,
  output logic               bus_addr_valid_o,
  output logic               rx_overflow_o
);

  standby_pkg::byte_t wdata_q;
  standby_pkg::byte_t byte_sel;
  logic               wvalid_q;
  logic               overflow_q;
  logic               byte_in;
  logic               buf_free;

  // Bus events from the lane in use
  assign bus_start_o = start_i[lane_sel_i];
  assign bus_rstart_o = rstart_i[lane_sel_i];
  assign bus_stop_o = stop_i[lane_sel_i];
  assign bus_addr_o = addr_i[lane_sel_i];
  assign bus_addr_valid_o = addr_valid_i[lane_sel_i];

  assign byte_in = data_valid_i[lane_sel_i];
  assign byte_sel = data_i[lane_sel_i];

  // Slot also frees in the cycle the queue takes the byte
  assign buf_free = ~wvalid_q | rx_queue_wready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wvalid_q   <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      overflow_q <= byte_in & ~buf_free;
      if (byte_in && buf_free) begin
        wvalid_q <= 1'b1;
      end else if (rx_queue_wready_i) begin
        wvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_in && buf_free) begin
      wdata_q <= byte_sel;
    end
  end

  assign rx_queue_wvalid_o = wvalid_q;
  assign rx_queue_wdata_o = wdata_q;
  assign rx_overflow_o = overflow_q;

endmodule

//--- hdl/controller_standby.sv
// Standby write path only; SCL is never driven and SDA is open-drain on both lanes
module controller_standby (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                ctrl_scl_i [standby_pkg::NumLanes],
  input  logic                ctrl_sda_i [standby_pkg::NumLanes],
  output logic                ctrl_scl_o [standby_pkg::NumLanes],
  output logic                ctrl_sda_o [standby_pkg::NumLanes],
  input  logic                phy_en_i,
  input  logic                i2c_active_en_i,
  input  logic                i2c_standby_en_i,
  input  logic                i3c_active_en_i,
  input  logic                i3c_standby_en_i,
  input  standby_pkg::addr7_t target_sta_addr_i,
  input  logic                target_sta_addr_valid_i,
  input  standby_pkg::addr7_t target_dyn_addr_i,
  input  logic                target_dyn_addr_valid_i,
  input  logic                rx_queue_wready_i,
  output logic                rx_queue_wvalid_o,
  output standby_pkg::byte_t  rx_queue_wdata_o,
  output logic                bus_start_o,
  output logic                bus_rstart_o,
  output logic                bus_stop_o,
  output standby_pkg::byte_t  bus_addr_o,
  output logic                bus_addr_valid_o,
  output logic                rx_overflow_o
);

  logic                lane_scl [standby_pkg::NumLanes];
  logic                lane_sda [standby_pkg::NumLanes];
  standby_pkg::addr7_t lane_addr [standby_pkg::NumLanes];
  logic                lane_addr_valid [standby_pkg::NumLanes];
  logic                lane_sel;
  logic                start [standby_pkg::NumLanes];
  logic                rstart [standby_pkg::NumLanes];
  logic                stop [standby_pkg::NumLanes];
  standby_pkg::byte_t  addr [standby_pkg::NumLanes];
  logic                addr_valid [standby_pkg::NumLanes];
  standby_pkg::byte_t  data [standby_pkg::NumLanes];
  logic                data_valid [standby_pkg::NumLanes];

  bus_input_sync xbus_input_sync (
    .clk_i                   (clk_i),
    .reset_i                 (reset_i),
    .ctrl_scl_i              (ctrl_scl_i),
    .ctrl_sda_i              (ctrl_sda_i),
    .phy_en_i                (phy_en_i),
    .i2c_active_en_i         (i2c_active_en_i),
    .i2c_standby_en_i        (i2c_standby_en_i),
    .i3c_active_en_i         (i3c_active_en_i),
    .i3c_standby_en_i        (i3c_standby_en_i),
    .target_sta_addr_i       (target_sta_addr_i),
    .target_sta_addr_valid_i (target_sta_addr_valid_i),
    .target_dyn_addr_i       (target_dyn_addr_i),
    .target_dyn_addr_valid_i (target_dyn_addr_valid_i),
    .lane_scl_o              (lane_scl),
    .lane_sda_o              (lane_sda),
    .lane_addr_o             (lane_addr),
    .lane_addr_valid_o       (lane_addr_valid),
    .lane_sel_o              (lane_sel)
  );

  for (genvar g = 0; g < standby_pkg::NumLanes; g++) begin : gen_lane
    // Target never stretches the clock
    assign ctrl_scl_o[g] = 1'b1;

    bus_frame_receiver xbus_frame_receiver (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .scl_i            (lane_scl[g]),
      .sda_i            (lane_sda[g]),
      .own_addr_i       (lane_addr[g]),
      .own_addr_valid_i (lane_addr_valid[g]),
      .sda_o            (ctrl_sda_o[g]),
      .start_o          (start[g]),
      .rstart_o         (rstart[g]),
      .stop_o           (stop[g]),
      .addr_o           (addr[g]),
      .addr_valid_o     (addr_valid[g]),
      .data_o           (data[g]),
      .data_valid_o     (data_valid[g])
    );
  end

  tti_rx_mux xtti_rx_mux (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .lane_sel_i        (lane_sel),
    .start_i           (start),
    .rstart_i          (rstart),
    .stop_i            (stop),
    .addr_i            (addr),
    .addr_valid_i      (addr_valid),
    .data_i            (data),
    .data_valid_i      (data_valid),
    .rx_queue_wready_i (rx_queue_wready_i),
    .rx_queue_wvalid_o (rx_queue_wvalid_o),
    .rx_queue_wdata_o  (rx_queue_wdata_o),
    .bus_start_o       (bus_start_o),
    .bus_rstart_o      (bus_rstart_o),
    .bus_stop_o        (bus_stop_o),
    .bus_addr_o        (bus_addr_o),
    .bus_addr_valid_o  (bus_addr_valid_o),
    .rx_overflow_o     (rx_overflow_o)
  );

endmodule

//--- verification/controller_standby_asserts.sv
// Two lanes assumed; lane idle flags come from the receiver state registers inside the top
module controller_standby_asserts (
  input logic                                clk_i,
  input logic                                reset_i,
  input logic                                wvalid_i,
  input logic                                wready_i,
  input standby_pkg::byte_t                  wdata_i,
  // start, rstart, stop, addr valid, overflow
  input logic [4:0]                          pulse_i,
  input logic [standby_pkg::NumLanes-1:0]    sda_i,
  input logic [standby_pkg::NumLanes-1:0]    lane_idle_i
);

  int unsigned fail_cnt = 0;

  // Queue write holds until taken
  wdata_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
    else begin
      fail_cnt++;
      $error("RX queue byte changed or dropped before wready");
    end

  one_condition: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(pulse_i[4:2]))
    else begin
      fail_cnt++;
      $error("More than one bus condition pulse in a cycle");
    end

  idle_release: assert property (@(posedge clk_i) disable iff (reset_i)
    (lane_idle_i & ~sda_i) == '0)
    else begin
      fail_cnt++;
      $error("SDA pulled low by an idle receiver");
    end

  reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> !wvalid_i && pulse_i == '0 && &sda_i)
    else begin
      fail_cnt++;
      $error("Outputs not at their reset values");
    end

endmodule

bind controller_standby controller_standby_asserts xasserts (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .wvalid_i    (rx_queue_wvalid_o),
  .wready_i    (rx_queue_wready_i),
  .wdata_i     (rx_queue_wdata_o),
  .pulse_i     ({bus_start_o, bus_rstart_o, bus_stop_o, bus_addr_valid_o, rx_overflow_o}),
  .sda_i       ({ctrl_sda_o[1], ctrl_sda_o[0]}),
  .lane_idle_i ({gen_lane[1].xbus_frame_receiver.state_q == standby_pkg::Idle,
                 gen_lane[0].xbus_frame_receiver.state_q == standby_pkg::Idle})
);

//--- verification/controller_standby_tb.sv
// Write frames only, 16 clocks per SCL bit; each frame waits for the RX queue to drain
module controller_standby_tb;

  logic                clk_i;
  logic                reset_i;
  logic                ctrl_scl_i [standby_pkg::NumLanes];
  logic                ctrl_sda_i [standby_pkg::NumLanes];
  logic                ctrl_scl_o [standby_pkg::NumLanes];
  logic                ctrl_sda_o [standby_pkg::NumLanes];
  logic                phy_en_i;
  logic                i2c_active_en_i;
  logic                i2c_standby_en_i;
  logic                i3c_active_en_i;
  logic                i3c_standby_en_i;
  standby_pkg::addr7_t target_sta_addr_i;
  logic                target_sta_addr_valid_i;
  standby_pkg::addr7_t target_dyn_addr_i;
  logic                target_dyn_addr_valid_i;
  logic                rx_queue_wready_i;
  logic                rx_queue_wvalid_o;
  standby_pkg::byte_t  rx_queue_wdata_o;
  logic                bus_start_o;
  logic                bus_rstart_o;
  logic                bus_stop_o;
  standby_pkg::byte_t  bus_addr_o;
  logic                bus_addr_valid_o;
  logic                rx_overflow_o;

  // Master side of the bus and the lane it drives this frame
  logic               m_scl;
  logic               m_sda;
  int                 lane;
  // wready pattern: 0 random, 1 held low, 2 held high
  int                 wr_mode;
  int                 byte_errs;
  int                 ack_errs;
  int                 count_errs;
  int                 timeouts;
  int                 ovf_cnt;
  // Event codes: 1 START, 2 repeated START, 3 STOP, 4 address
  int                 ev_q [$];
  int                 exp_ev [$];
  standby_pkg::byte_t addr_q [$];
  standby_pkg::byte_t exp_addr [$];
  standby_pkg::byte_t data_q [$];
  standby_pkg::byte_t exp_data [$];

  controller_standby dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Sample outputs after the falling edge, then drive the next inputs
  task automatic tick();
    logic wr;
    @(negedge clk_i);
    if (bus_start_o) ev_q.push_back(1);
    if (bus_rstart_o) ev_q.push_back(2);
    if (bus_stop_o) ev_q.push_back(3);
    if (bus_addr_valid_o) begin
      ev_q.push_back(4);
      addr_q.push_back(bus_addr_o);
    end
    if (rx_overflow_o) ovf_cnt++;
    // Target never holds SCL low
    for (int l = 0; l < standby_pkg::NumLanes; l++) begin
      check_ack(1'b1, ctrl_scl_o[l], "ctrl_scl_o release");
    end
    case (wr_mode)
      0: wr = 1'($urandom % 2);
      1: wr = 1'b0;
      default: wr = 1'b1;
    endcase
    // Byte moves on the coming rising edge
    if (rx_queue_wvalid_o && wr) data_q.push_back(rx_queue_wdata_o);
    rx_queue_wready_i = wr;
    for (int l = 0; l < standby_pkg::NumLanes; l++) begin
      ctrl_scl_i[l] = (l == lane) ? m_scl : 1'b1;
      ctrl_sda_i[l] = ((l == lane) ? m_sda : 1'b1) & ctrl_sda_o[l];
    end
  endtask

  task automatic half_period();
    repeat (8) tick();
  endtask

  task automatic send_bit(input logic b, output logic seen);
    m_sda = b;
    // SCL fall already took the first cycle of the low half
    repeat (7) tick();
    m_scl = 1'b1;
    half_period();
    seen = ctrl_sda_i[lane];
    m_scl = 1'b0;
    tick();
  endtask

  task automatic send_byte(input standby_pkg::byte_t b, output logic ack);
    logic echo;
    for (int i = 7; i >= 0; i--) begin
      send_bit(b[i], echo);
      check_ack(b[i], echo, "SDA level during data bit");
    end
    send_bit(1'b1, ack);
  endtask

  task automatic send_start(input logic repeated);
    if (repeated) begin
      m_sda = 1'b1;
      half_period();
      m_scl = 1'b1;
      half_period();
    end
    m_sda = 1'b0;
    half_period();
    m_scl = 1'b0;
    tick();
  endtask

  task automatic send_stop();
    m_sda = 1'b0;
    half_period();
    m_scl = 1'b1;
    half_period();
    m_sda = 1'b1;
    half_period();
  endtask

  task automatic check_byte(input standby_pkg::byte_t exp, input standby_pkg::byte_t got,
                            input string what);
    if (got !== exp) begin
      byte_errs++;
      $display("Fail at %0t: %s expected %02h, got %02h", $time, what, exp, got);
    end
  endtask

  task automatic check_ack(input logic exp, input logic got, input string what);
    if (got !== exp) begin
      ack_errs++;
      $display("Fail at %0t: %s expected %b, got %b", $time, what, exp, got);
    end
  endtask

  task automatic check_count(input int exp, input int got, input string what);
    if (got != exp) begin
      count_errs++;
      $display("Fail at %0t: %s expected %0d, got %0d", $time, what, exp, got);
    end
  endtask

  // Lane 1 answers to the dynamic address once it is valid
  function automatic standby_pkg::addr7_t own_addr(input int l);
    if (l == standby_pkg::LaneI3c && target_dyn_addr_valid_i) return target_dyn_addr_i;
    return target_sta_addr_i;
  endfunction

  task automatic run_frame(input int f);
    int                 mode;
    int                 n;
    int                 segs;
    int                 exp_ovf;
    logic               active;
    logic               match;
    logic               ack;
    standby_pkg::byte_t a;
    standby_pkg::byte_t d;
    mode = (f < 2) ? 0 : int'($urandom % 4);
    i2c_standby_en_i = (mode == 0);
    i2c_active_en_i = (mode == 1);
    i3c_standby_en_i = (mode == 2);
    i3c_active_en_i = (mode == 3);
    target_sta_addr_i = 7'($urandom);
    target_dyn_addr_i = 7'($urandom);
    target_dyn_addr_valid_i = 1'($urandom);
    lane = (mode >= 2) ? standby_pkg::LaneI3c : standby_pkg::LaneI2c;
    active = 1'b1;
    if (f >= 2 && $urandom % 4 == 0) begin
      lane = 1 - lane;
      active = 1'b0;
    end
    if (f < 2 || $urandom % 2 == 1) begin
      a = {own_addr(lane), 1'b0};
      if (f >= 2 && $urandom % 4 == 0) a[0] = 1'b1;
    end else begin
      a = 8'($urandom);
    end
    match = active && (a[7:1] == own_addr(lane)) && !a[0];
    n = (f == 1) ? 2 + int'($urandom % 3) : 1 + int'($urandom % 4);
    segs = 1 + int'($urandom % 2);
    wr_mode = (f == 1 || $urandom % 5 == 0) ? 1 : 0;
    exp_ovf = 0;
    for (int s = 0; s < segs; s++) begin
      send_start(s > 0);
      if (active) begin
        exp_ev.push_back((s > 0) ? 2 : 1);
        exp_ev.push_back(4);
        exp_addr.push_back(a);
      end
      send_byte(a, ack);
      check_ack(!match, ack, "address ACK");
      for (int i = 0; i < n; i++) begin
        d = 8'($urandom);
        send_byte(d, ack);
        check_ack(!match, ack, "data ACK");
        // With wready low only the first byte of the frame survives
        if (match && (wr_mode == 0 || exp_data.size() == 0)) exp_data.push_back(d);
        else if (match) exp_ovf++;
      end
    end
    send_stop();
    if (active) exp_ev.push_back(3);
    wr_mode = 2;
    for (int t = 0; t < 50 && rx_queue_wvalid_o; t++) tick();
    if (rx_queue_wvalid_o) begin
      timeouts++;
      $display("Timeout at %0t: RX queue write still pending after STOP", $time);
    end
    check_count(exp_ev.size(), ev_q.size(), "bus event count");
    foreach (exp_ev[i]) begin
      if (i < ev_q.size()) check_count(exp_ev[i], ev_q[i], "bus event order");
    end
    check_count(exp_addr.size(), addr_q.size(), "address reports");
    foreach (exp_addr[i]) begin
      if (i < addr_q.size()) check_byte(exp_addr[i], addr_q[i], "bus_addr_o");
    end
    check_count(exp_data.size(), data_q.size(), "RX queue writes");
    foreach (exp_data[i]) begin
      if (i < data_q.size()) check_byte(exp_data[i], data_q[i], "rx_queue_wdata_o");
    end
    check_count(exp_ovf, ovf_cnt, "overflow pulses");
    ev_q.delete();
    exp_ev.delete();
    addr_q.delete();
    exp_addr.delete();
    data_q.delete();
    exp_data.delete();
    ovf_cnt = 0;
  endtask

  initial begin
    int unsigned sva_errs;
    void'($urandom(46));
    byte_errs = 0;
    ack_errs = 0;
    count_errs = 0;
    timeouts = 0;
    ovf_cnt = 0;
    reset_i = 1'b1;
    phy_en_i = 1'b1;
    i2c_active_en_i = 1'b0;
    i2c_standby_en_i = 1'b1;
    i3c_active_en_i = 1'b0;
    i3c_standby_en_i = 1'b0;
    target_sta_addr_i = '0;
    target_sta_addr_valid_i = 1'b1;
    target_dyn_addr_i = '0;
    target_dyn_addr_valid_i = 1'b0;
    rx_queue_wready_i = 1'b1;
    m_scl = 1'b1;
    m_sda = 1'b1;
    lane = 0;
    wr_mode = 2;
    for (int l = 0; l < standby_pkg::NumLanes; l++) begin
      ctrl_scl_i[l] = 1'b1;
      ctrl_sda_i[l] = 1'b1;
    end
    repeat (8) tick();
    reset_i = 1'b0;
    for (int f = 0; f < 60 && timeouts == 0; f++) run_frame(f);
    sva_errs = dut_i.xasserts.fail_cnt;
    $display("Errors: byte %0d, ack %0d, count %0d, timeout %0d, assertion %0d",
             byte_errs, ack_errs, count_errs, timeouts, sva_errs);
    if (byte_errs + ack_errs + count_errs + timeouts + int'(sva_errs) == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
hdl/standby_pkg.sv
hdl/bus_input_sync.sv
hdl/bus_frame_receiver.sv
hdl/tti_rx_mux.sv
hdl/controller_standby.sv
verification/controller_standby_asserts.sv
verification/controller_standby_tb.sv

//--- Makefile
TOP = controller_standby_tb

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "TB PASSED" sim.log

build:
	verilator --binary -sv --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir

lint:
	verilator --lint-only -sv --timing -Wall --top-module controller_standby -f verilog.f

clean:
	rm -rf obj_dir sim.log
